//--- project.f
+incdir+.
cpu_pkg.sv
instr_decode.sv
sequencer.sv
alu.sv
exec_unit.sv
cpu.sv
cpu_tb.sv

//--- cpu_tb.sv
// Testbench of the 6502-style core
// Random program with random rdy stalls; an instruction-level model gives
// the expected zero-page writes, which are compared with the bus
`timescale 1ns/100ps
`default_nettype none

`include "cpu_settings.svh"

module cpu_tb;

    localparam int N_INSTR    = 200;
    localparam int MAX_CYCLES = N_INSTR * 5 * 2 + 100;  // Worst path, doubled for stalls

    logic           clk;
    logic           reset;
    logic           rdy;
    cpu_pkg::byte_t data_in;
    cpu_pkg::addr_t ab;
    cpu_pkg::byte_t data_out;
    logic           we;

    cpu_pkg::byte_t mem [0:65535];     // Bus memory
    cpu_pkg::byte_t op_table [44];     // Kept opcodes, stores first
    cpu_pkg::byte_t zmem [64];         // Model copy of the zp data
    cpu_pkg::addr_t exp_addr [$];      // Expected writes, in order
    cpu_pkg::byte_t exp_data [$];
    cpu_pkg::byte_t m_a;
    cpu_pkg::byte_t m_x;
    cpu_pkg::byte_t m_y;
    logic           m_c;
    logic           m_d;
    cpu_pkg::addr_t pc;
    cpu_pkg::addr_t prog_end;
    cpu_pkg::addr_t want_addr;
    cpu_pkg::byte_t want_data;
    cpu_pkg::byte_t opc;
    cpu_pkg::byte_t opd;
    int unsigned    seed;
    int             i;
    int             k;
    int             cycles;
    int             errors;
    int             checks;
    int             writes_seen;
    logic           boot_checked;
    logic           done;

    cpu dut_i (
        .clk      (clk),
        .reset    (reset),
        .rdy      (rdy),
        .data_in  (data_in),
        .ab       (ab),
        .data_out (data_out),
        .we       (we)
    );

    always #4 clk = ~clk;  // 8 ns period

    task automatic check_addr(input string name, input cpu_pkg::addr_t exp,
                              input cpu_pkg::addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_data(input string name, input cpu_pkg::byte_t exp,
                              input cpu_pkg::byte_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    // {carry, result}; kind is opcode bits 6:5, ASL ROL LSR ROR
    function automatic logic [8:0] shift_result(input cpu_pkg::byte_t v,
                                                input logic [1:0] kind, input logic cin);
        case (kind)
            2'b00:   return {v, 1'b0};
            2'b01:   return {v, cin};
            2'b10:   return {v[0], 1'b0, v[7:1]};
            default: return {v[0], cin, v[7:1]};
        endcase
    endfunction

    // ADC or SBC as {carry, result}, binary or decimal
    function automatic logic [8:0] add_result(input cpu_pkg::byte_t a, input cpu_pkg::byte_t b,
                                              input logic cin, input logic dec, input logic sub);
        cpu_pkg::byte_t bb;
        logic [4:0]     lo;
        logic [4:0]     hi;
        logic           hc;
        logic           co;
        logic [3:0]     rl;
        logic [3:0]     rh;
        bb = sub ? ~b : b;
        if (!dec) begin
            return {1'b0, a} + {1'b0, bb} + cin;
        end
        lo = a[3:0] + bb[3:0] + cin;
        hc = sub ? lo[4] : (lo > 5'd9);
        hi = a[7:4] + bb[7:4] + hc;
        co = sub ? hi[4] : (hi > 5'd9);
        if (sub) begin
            rl = lo[3:0] + (hc ? 4'd0 : 4'd10);  // Borrowing digit gets 10
            rh = hi[3:0] + (co ? 4'd0 : 4'd10);
        end else begin
            rl = lo[3:0] + (hc ? 4'd6 : 4'd0);   // Carrying digit gets 6
            rh = hi[3:0] + (co ? 4'd6 : 4'd0);
        end
        return {co, rh, rl};
    endfunction

    task automatic record_write(input cpu_pkg::byte_t zp, input cpu_pkg::byte_t val);
        zmem[zp[5:0]] = val;
        exp_addr.push_back({`ZERO_PAGE, zp});
        exp_data.push_back(val);
    endtask

    // One instruction of the model
    task automatic execute_instr(input cpu_pkg::byte_t op, input cpu_pkg::byte_t arg);
        cpu_pkg::byte_t v;
        logic [8:0]     r;
        v = ((op[3:0] == 4'h9) || (op == 8'hA2) || (op == 8'hA0)) ? arg : zmem[arg[5:0]];
        case (op)
            8'hA9, 8'hA5: m_a = v;
            8'hA2, 8'hA6: m_x = v;
            8'hA0, 8'hA4: m_y = v;
            8'h85:        record_write(arg, m_a);
            8'h86:        record_write(arg, m_x);
            8'h84:        record_write(arg, m_y);
            8'h69, 8'h65: {m_c, m_a} = add_result(m_a, v, m_c, m_d, 1'b0);
            8'hE9, 8'hE5: {m_c, m_a} = add_result(m_a, v, m_c, m_d, 1'b1);
            8'h29, 8'h25: m_a = m_a & v;
            8'h09, 8'h05: m_a = m_a | v;
            8'h49, 8'h45: m_a = m_a ^ v;
            8'hC9, 8'hC5: m_c = m_a >= v;
            8'h0A, 8'h2A, 8'h4A, 8'h6A: {m_c, m_a} = shift_result(m_a, op[6:5], m_c);
            8'h06, 8'h26, 8'h46, 8'h66: begin
                r   = shift_result(v, op[6:5], m_c);
                m_c = r[8];
                record_write(arg, r[7:0]);
            end
            8'hE6: record_write(arg, v + 8'd1);
            8'hC6: record_write(arg, v - 8'd1);
            8'hE8: m_x = m_x + 8'd1;
            8'hC8: m_y = m_y + 8'd1;
            8'hCA: m_x = m_x - 8'd1;
            8'h88: m_y = m_y - 8'd1;
            8'hAA: m_x = m_a;
            8'hA8: m_y = m_a;
            8'h8A: m_a = m_x;
            8'h98: m_a = m_y;
            8'h18: m_c = 1'b0;
            8'h38: m_c = 1'b1;
            8'hD8: m_d = 1'b0;
            8'hF8: m_d = 1'b1;
            default: ;  // NOP
        endcase
    endtask

    task automatic end_run;
        $display("checks %0d, writes %0d, errors %0d", checks, writes_seen, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    // Bus memory, reads and writes only in cycles with rdy high
    always @(posedge clk) begin
        if (rdy) begin
            data_in <= mem[ab];
            if (we) begin
                mem[ab] <= data_out;
            end
        end
    end

    always @(posedge clk) begin
        if (!reset) begin
            rdy <= ($urandom % 4) != 0;  // Low about a quarter of cycles
        end
    end

    // Bus monitor
    always @(posedge clk) begin
        if (!reset) begin
            if (!boot_checked) begin
                if (we) begin
                    errors++;
                    $display("write enable is high before the first fetch after reset");
                end
                if (rdy) begin
                    check_addr("first fetch", `RESET_PC, ab);
                    boot_checked = 1'b1;
                end
            end
            if (we && rdy) begin
                if (exp_addr.size() == 0) begin
                    errors++;
                    $display("extra write of %h to %h after the expected writes", data_out, ab);
                end else begin
                    want_addr = exp_addr.pop_front();
                    want_data = exp_data.pop_front();
                    check_addr($sformatf("write %0d address", writes_seen), want_addr, ab);
                    check_data($sformatf("write %0d data", writes_seen), want_data, data_out);
                end
                writes_seen++;
            end
            if (rdy && (ab == prog_end + 16'd4)) begin
                done <= 1'b1;  // Running the NOP tail
            end
        end
    end

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        rdy          = 1'b1;
        data_in      = '0;
        done         = 1'b0;
        boot_checked = 1'b0;
        errors       = 0;
        checks       = 0;
        writes_seen  = 0;
        seed         = 32'h9fe285d4;
        void'($urandom(seed));
        op_table = '{8'h85, 8'h86, 8'h84,
                     8'hA9, 8'hA2, 8'hA0, 8'h69, 8'hE9, 8'h29, 8'h09, 8'h49, 8'hC9,
                     8'hA5, 8'hA6, 8'hA4, 8'h65, 8'hE5, 8'h25, 8'h05, 8'h45, 8'hC5,
                     8'h0A, 8'h4A, 8'h2A, 8'h6A, 8'h06, 8'h46, 8'h26, 8'h66, 8'hE6, 8'hC6,
                     8'hE8, 8'hC8, 8'hCA, 8'h88, 8'hAA, 8'hA8, 8'h8A, 8'h98,
                     8'h18, 8'h38, 8'hD8, 8'hF8, 8'hEA};
        for (i = 0; i < 65536; i++) begin
            mem[i] = cpu_pkg::byte_t'(i[7:0] ^ i[15:8] ^ 8'h5A);
        end
        for (i = 0; i < 64; i++) begin
            zmem[i] = cpu_pkg::byte_t'($urandom);
            mem[i]  = zmem[i];
        end
        m_a = '0;  // Registers and flags clear at reset
        m_x = '0;
        m_y = '0;
        m_c = 1'b0;
        m_d = 1'b0;
        pc  = `RESET_PC;
        for (i = 0; i < N_INSTR; i++) begin
            k   = (($urandom % 4) == 0) ? ($urandom % 3) : ($urandom % 44);
            opc = op_table[k];
            opd = '0;
            mem[pc] = opc;
            pc++;
            if ((opc[3:0] == 4'h9) || (opc == 8'hA2) || (opc == 8'hA0)) begin
                opd = cpu_pkg::byte_t'($urandom);
            end else if (opc[3:2] == 2'b01) begin
                opd = cpu_pkg::byte_t'($urandom % 64);  // zp 0x00 to 0x3F
            end
            if ((opc[3:2] == 2'b01) || (opc[3:0] == 4'h9) || (opc == 8'hA2) ||
                (opc == 8'hA0)) begin
                mem[pc] = opd;
                pc++;
            end
            execute_instr(opc, opd);
        end
        prog_end = pc;
        for (i = 0; i < 256; i++) begin
            mem[prog_end + i] = 8'hEA;
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        wait (done);
        repeat (8) @(posedge clk);
        if (exp_addr.size() != 0) begin
            errors++;
            $display("%0d expected writes never appeared on the bus", exp_addr.size());
        end
        end_run();
    end

    // Watchdog
    initial begin
        cycles = 0;
        while (!done && (cycles < MAX_CYCLES)) begin
            @(posedge clk);
            cycles++;
        end
        if (!done) begin
            errors++;
            $display("timeout, program not finished after %0d cycles", MAX_CYCLES);
            end_run();
        end
    end

endmodule

`default_nettype wire

//--- cpu.sv
// Top of the 6502-style core
// Joins the sequencer, opcode decoder and execute unit
`timescale 1ns/100ps
`default_nettype none

module cpu (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           rdy,
    input  wire cpu_pkg::byte_t data_in,
    output cpu_pkg::addr_t      ab,
    output cpu_pkg::byte_t      data_out,
    output logic                we
);

    cpu_pkg::state_t     state;
    cpu_pkg::byte_t      data_mux;     // Read byte after stall hold
    cpu_pkg::addr_mode_t addr_mode;
    cpu_pkg::alu_op_t    alu_op;
    cpu_pkg::reg_sel_t   src_reg;
    cpu_pkg::reg_sel_t   dst_reg;
    logic                decode_load;
    logic                d_flag;
    logic                load_reg;
    logic                store;
    logic                write_back;
    logic                load_only;
    logic                inc;
    logic                shift;
    logic                rotate;
    logic                shift_right;
    logic                compare;
    logic                adc_sbc;
    logic                adc_bcd;
    logic                clc;
    logic                sec;
    logic                cld;
    logic                sed;

    sequencer sequencer_i (
        .clk         (clk),
        .reset       (reset),
        .rdy         (rdy),
        .data_in     (data_in),
        .addr_mode   (addr_mode),
        .write_back  (write_back),
        .store       (store),
        .state       (state),
        .decode_load (decode_load),
        .data_mux    (data_mux),
        .ab          (ab),
        .we          (we)
    );

    instr_decode instr_decode_i (
        .clk         (clk),
        .reset       (reset),
        .decode_load (decode_load),
        .ir          (data_mux),      // Opcode is on the read bus in DECODE
        .d_flag      (d_flag),
        .addr_mode   (addr_mode),
        .alu_op      (alu_op),
        .src_reg     (src_reg),
        .dst_reg     (dst_reg),
        .load_reg    (load_reg),
        .store       (store),
        .write_back  (write_back),
        .load_only   (load_only),
        .inc         (inc),
        .shift       (shift),
        .rotate      (rotate),
        .shift_right (shift_right),
        .compare     (compare),
        .adc_sbc     (adc_sbc),
        .adc_bcd     (adc_bcd),
        .clc         (clc),
        .sec         (sec),
        .cld         (cld),
        .sed         (sed)
    );

    exec_unit exec_unit_i (
        .clk         (clk),
        .reset       (reset),
        .rdy         (rdy),
        .state       (state),
        .data_mux    (data_mux),
        .alu_op      (alu_op),
        .src_reg     (src_reg),
        .dst_reg     (dst_reg),
        .load_reg    (load_reg),
        .load_only   (load_only),
        .inc         (inc),
        .shift       (shift),
        .rotate      (rotate),
        .shift_right (shift_right),
        .compare     (compare),
        .adc_sbc     (adc_sbc),
        .adc_bcd     (adc_bcd),
        .clc         (clc),
        .sec         (sec),
        .cld         (cld),
        .sed         (sed),
        .data_out    (data_out),
        .d_flag      (d_flag)
    );

endmodule

`default_nettype wire

//--- exec_unit.sv
// Execute unit
// Register file, carry and decimal flags, ALU operand selection and
// decimal adjust of results before write-back
`timescale 1ns/100ps
`default_nettype none

module exec_unit (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              rdy,
    input  wire cpu_pkg::state_t   state,
    input  wire cpu_pkg::byte_t    data_mux,
    input  wire cpu_pkg::alu_op_t  alu_op,
    input  wire cpu_pkg::reg_sel_t src_reg,
    input  wire cpu_pkg::reg_sel_t dst_reg,
    input  wire logic              load_reg,
    input  wire logic              load_only,
    input  wire logic              inc,
    input  wire logic              shift,
    input  wire logic              rotate,
    input  wire logic              shift_right,
    input  wire logic              compare,
    input  wire logic              adc_sbc,
    input  wire logic              adc_bcd,
    input  wire logic              clc,
    input  wire logic              sec,
    input  wire logic              cld,
    input  wire logic              sed,
    output cpu_pkg::byte_t         data_out,
    output logic                   d_flag
);

    cpu_pkg::byte_t    regs [3];    // A, X, Y
    cpu_pkg::reg_sel_t reg_sel;
    cpu_pkg::byte_t    reg_q;       // Selected register
    cpu_pkg::alu_op_t  op_cur;
    cpu_pkg::byte_t    ai;
    cpu_pkg::byte_t    bi;
    cpu_pkg::byte_t    alu_out;
    logic              ci;
    logic              co;
    logic              hc;
    logic              alu_cycle;   // ALU runs the instruction op
    logic              c_flag;
    logic              shift_done;  // Shift result waits in the ALU
    logic              adj_bcd;
    logic [3:0]        adj_l;
    logic [3:0]        adj_h;

    // DECODE writes the previous instruction's result
    assign reg_sel   = (state == cpu_pkg::DECODE) ? dst_reg : src_reg;
    assign reg_q     = regs[reg_sel];
    assign alu_cycle = (state == cpu_pkg::FETCH) || (state == cpu_pkg::REG) ||
                       (state == cpu_pkg::READ);
    assign op_cur    = alu_cycle ? alu_op : cpu_pkg::ADD;

    always_comb begin
        ai = '0;
        bi = data_mux;
        ci = 1'b0;
        case (state)
            cpu_pkg::REG,
            cpu_pkg::READ: begin
                ai = (state == cpu_pkg::READ) ? data_mux : reg_q;
                bi = '0;
                ci = rotate ? c_flag : (!shift && inc);  // +1 for increments
            end
            cpu_pkg::FETCH: begin
                ai = load_only ? '0 : reg_q;
                ci = rotate ? c_flag :
                     compare ? 1'b1 :                  // CMP has no borrow in
                     (shift || load_only) ? 1'b0 : c_flag;
            end
            default: ;
        endcase
    end

    alu alu_i (
        .clk     (clk),
        .rdy     (rdy),
        .op      (op_cur),
        .right   (alu_cycle && shift_right),
        .ai      (ai),
        .bi      (bi),
        .ci      (ci),
        .bcd     (adc_bcd && (state == cpu_pkg::FETCH)),
        .alu_out (alu_out),
        .co      (co),
        .hc      (hc)
    );

    // Decimal adjust, +6 after ADC carry, +10 after SBC borrow
    assign adj_bcd = adc_sbc && d_flag;
    assign adj_l   = !adj_bcd ? 4'd0 : adc_bcd ? (hc ? 4'd6 : 4'd0) : (hc ? 4'd0 : 4'd10);
    assign adj_h   = !adj_bcd ? 4'd0 : adc_bcd ? (co ? 4'd6 : 4'd0) : (co ? 4'd0 : 4'd10);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 3; i++) begin
                regs[i] <= '0;
            end
        end else if (rdy && load_reg && (state == cpu_pkg::DECODE)) begin
            regs[reg_sel] <= {alu_out[7:4] + adj_h, alu_out[3:0] + adj_l};
        end
    end

    // Flags
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            c_flag     <= 1'b0;
            d_flag     <= 1'b0;
            shift_done <= 1'b0;
        end else if (rdy) begin
            shift_done <= shift && ((state == cpu_pkg::REG) || (state == cpu_pkg::READ));
            if (shift_done) begin
                c_flag <= co;                // Bit shifted out
            end else if (state == cpu_pkg::DECODE) begin
                if (adc_sbc || compare) begin
                    c_flag <= co;
                end else if (sec) begin
                    c_flag <= 1'b1;
                end else if (clc) begin
                    c_flag <= 1'b0;
                end
            end
            if (state == cpu_pkg::DECODE) begin
                if (sed) begin
                    d_flag <= 1'b1;
                end else if (cld) begin
                    d_flag <= 1'b0;
                end
            end
        end
    end

    assign data_out = (state == cpu_pkg::WRITE) ? alu_out : reg_q;  // RMW result or store

endmodule

`default_nettype wire

//--- alu.sv
// 8-bit ALU
// Logic ops, add, subtract and shifts with decimal nibble carries
// Result and carries are registered
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  wire logic             clk,
    input  wire logic             rdy,
    input  wire cpu_pkg::alu_op_t op,
    input  wire logic             right,
    input  wire cpu_pkg::byte_t   ai,
    input  wire cpu_pkg::byte_t   bi,
    input  wire logic             ci,
    input  wire logic             bcd,
    output cpu_pkg::byte_t        alu_out,
    output logic                  co,
    output logic                  hc
);

    logic [8:0]     logic_res;  // Bit 8 is the bit shifted out right
    cpu_pkg::byte_t b_term;     // Second adder operand
    logic           add_ci;
    logic [4:0]     sum_l;
    logic [4:0]     sum_h;
    logic           half;       // Carry into the high nibble

    always_comb begin
        case (op[1:0])
            2'b00:   logic_res = {1'b0, ai | bi};
            2'b01:   logic_res = {1'b0, ai & bi};
            2'b10:   logic_res = {1'b0, ai ^ bi};
            default: logic_res = {1'b0, ai};
        endcase
        if (right) begin
            logic_res = {ai[0], ci, ai[7:1]};  // Carry enters at the top
        end
        case (op[3:2])
            2'b00:   b_term = bi;
            2'b01:   b_term = ~bi;              // Subtract
            2'b10:   b_term = logic_res[7:0];   // Doubling gives the left shift
            default: b_term = '0;
        endcase
        add_ci = (right || (op[3:2] == 2'b11)) ? 1'b0 : ci;
        sum_l  = {1'b0, logic_res[3:0]} + {1'b0, b_term[3:0]} + {4'b0, add_ci};
        half   = sum_l[4] || (bcd && (sum_l[3:1] >= 3'd5));  // Decimal digit above 9
        sum_h  = logic_res[8:4] + {1'b0, b_term[7:4]} + {4'b0, half};
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            alu_out <= {sum_h[3:0], sum_l[3:0]};
            co      <= sum_h[4] || (bcd && (sum_h[3:1] >= 3'd5));
            hc      <= half;
        end
    end

endmodule

`default_nettype wire

//--- sequencer.sv
// Instruction sequencer
// Walks each opcode through its cycles, keeps the PC and drives the address
// bus and write enable, holding the read byte across rdy stalls
`timescale 1ns/100ps
`default_nettype none

`include "cpu_settings.svh"

module sequencer (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                rdy,
    input  wire cpu_pkg::byte_t      data_in,
    input  wire cpu_pkg::addr_mode_t addr_mode,
    input  wire logic                write_back,
    input  wire logic                store,
    output cpu_pkg::state_t          state,
    output logic                     decode_load,
    output cpu_pkg::byte_t           data_mux,
    output cpu_pkg::addr_t           ab,
    output logic                     we
);

    cpu_pkg::addr_t pc;         // Program counter
    cpu_pkg::addr_t ab_hold;    // Address of the last completed cycle
    cpu_pkg::byte_t data_hold;  // First byte seen after rdy fell
    logic           rdy_q;      // rdy one cycle back
    logic           pc_inc;

    // Stall hold of the read bus
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rdy_q <= 1'b1;
        end else begin
            rdy_q <= rdy;
        end
    end

    always_ff @(posedge clk) begin
        if (!rdy && rdy_q) begin
            data_hold <= data_in;  // Capture on first stall cycle
        end
    end

    assign data_mux = rdy_q ? data_in : data_hold;

    assign decode_load = (state == cpu_pkg::DECODE) && rdy;

    // Main state machine
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= cpu_pkg::BOOT;
        end else if (rdy) begin
            case (state)
                cpu_pkg::DECODE: begin
                    case (addr_mode)
                        cpu_pkg::IMMEDIATE: state <= cpu_pkg::FETCH;
                        cpu_pkg::ZERO_PAGE: state <= cpu_pkg::ZP0;
                        default:            state <= cpu_pkg::REG;
                    endcase
                end
                cpu_pkg::ZP0:   state <= write_back ? cpu_pkg::READ : cpu_pkg::FETCH;
                cpu_pkg::READ:  state <= cpu_pkg::WRITE;
                cpu_pkg::WRITE: state <= cpu_pkg::FETCH;
                default:        state <= cpu_pkg::DECODE;  // BOOT, FETCH, REG
            endcase
        end
    end

    // Opcode and operand fetches advance the PC
    assign pc_inc = (state == cpu_pkg::BOOT) || (state == cpu_pkg::DECODE) ||
                    (state == cpu_pkg::FETCH);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else if (rdy) begin
            pc <= pc + cpu_pkg::addr_t'(pc_inc);
        end
    end

    // Address mux
    always_comb begin
        case (state)
            cpu_pkg::ZP0:   ab = {`ZERO_PAGE, data_mux};  // Operand is the zp address
            cpu_pkg::REG,                                 // Re-read, it is the next opcode
            cpu_pkg::READ,
            cpu_pkg::WRITE: ab = ab_hold;                 // Stay on the zp location
            default:        ab = pc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            ab_hold <= ab;
        end
    end

    assign we = (state == cpu_pkg::WRITE) || ((state == cpu_pkg::ZP0) && store);

endmodule

`default_nettype wire

//--- instr_decode.sv
// Opcode decoder
// Gives the addressing class straight from the opcode and latches the
// per-instruction controls while the sequencer is in DECODE
`timescale 1ns/100ps
`default_nettype none

module instr_decode (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                decode_load,
    input  wire cpu_pkg::byte_t      ir,
    input  wire logic                d_flag,
    output cpu_pkg::addr_mode_t      addr_mode,
    output cpu_pkg::alu_op_t         alu_op,
    output cpu_pkg::reg_sel_t        src_reg,
    output cpu_pkg::reg_sel_t        dst_reg,
    output logic                     load_reg,
    output logic                     store,
    output logic                     write_back,
    output logic                     load_only,
    output logic                     inc,
    output logic                     shift,
    output logic                     rotate,
    output logic                     shift_right,
    output logic                     compare,
    output logic                     adc_sbc,
    output logic                     adc_bcd,
    output logic                     clc,
    output logic                     sec,
    output logic                     cld,
    output logic                     sed
);

    // Addressing class, used in the DECODE cycle itself
    always_comb begin
        casez (ir)
            8'b1??0_00?0,                                 // LDX, LDY imm
            8'b???0_1001: addr_mode = cpu_pkg::IMMEDIATE; // Group one imm
            8'b???0_01??: addr_mode = cpu_pkg::ZERO_PAGE; // All zp columns
            default:      addr_mode = cpu_pkg::IMPLIED;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            alu_op      <= cpu_pkg::ADD;
            src_reg     <= cpu_pkg::A;
            dst_reg     <= cpu_pkg::A;
            load_reg    <= 1'b0;
            store       <= 1'b0;
            write_back  <= 1'b0;
            load_only   <= 1'b0;
            inc         <= 1'b0;
            shift       <= 1'b0;
            rotate      <= 1'b0;
            shift_right <= 1'b0;
            compare     <= 1'b0;
            adc_sbc     <= 1'b0;
            adc_bcd     <= 1'b0;
            clc         <= 1'b0;
            sec         <= 1'b0;
            cld         <= 1'b0;
            sed         <= 1'b0;
        end else if (decode_load) begin
            load_reg    <= (ir ==? 8'b0??0_1010) || (ir ==? 8'b0???_??01) ||
                           (ir ==? 8'b1?1?_??01) || (ir ==? 8'b1010_???0) ||
                           (ir ==? 8'b100?_10?0) || (ir ==? 8'b1100_10?0) ||
                           (ir == 8'hE8);
            dst_reg     <= ((ir == 8'hE8) || (ir == 8'hCA) || (ir ==? 8'b101?_??10)) ?
                           cpu_pkg::X :                        // INX DEX LDX TAX
                           ((ir ==? 8'b1?00_1000) || (ir ==? 8'b101?_?100) ||
                            (ir ==? 8'b1010_?000)) ? cpu_pkg::Y : cpu_pkg::A;
            src_reg     <= ((ir ==? 8'b100?_?110) || (ir ==? 8'b100?_1?10) ||
                            (ir == 8'hE8) || (ir == 8'hCA)) ? cpu_pkg::X :
                           ((ir ==? 8'b100?_?100) || (ir == 8'h98) ||
                            (ir ==? 8'b1?00_1000)) ? cpu_pkg::Y : cpu_pkg::A;
            store       <= (ir ==? 8'b100?_?1?0) || (ir ==? 8'b100?_??01);  // STX STY STA
            write_back  <= (ir ==? 8'b0???_?110) || (ir ==? 8'b11??_?110);  // Shifts, INC, DEC
            load_only   <= ir ==? 8'b101?_????;
            inc         <= (ir ==? 8'b111?_?110) || (ir ==? 8'b11?0_1000);  // INC INX INY
            shift       <= (ir ==? 8'b0???_?110) || (ir ==? 8'b0???_1010);
            rotate      <= (ir ==? 8'b0?1?_1010) || (ir ==? 8'b0?1?_?110);
            shift_right <= ir ==? 8'b01??_??10;                          // LSR ROR
            compare     <= ir ==? 8'b110?_??01;
            adc_sbc     <= ir ==? 8'b?11?_??01;
            // Decimal flag may be changing in this very cycle
            adc_bcd     <= (ir ==? 8'b011?_??01) && (d_flag || sed) && !cld;
            casez (ir)
                8'b00??_??10: alu_op <= cpu_pkg::ROL;  // ASL ROL
                8'b01??_??10: alu_op <= cpu_pkg::PASS; // LSR ROR via right shift
                8'b1000_1000,
                8'b1100_1010,
                8'b110?_?110,
                8'b11??_??01: alu_op <= cpu_pkg::SUB;  // DEY DEX DEC CMP SBC
                8'b000?_??01: alu_op <= cpu_pkg::OR;
                8'b001?_??01: alu_op <= cpu_pkg::AND;
                8'b010?_??01: alu_op <= cpu_pkg::EOR;
                default:      alu_op <= cpu_pkg::ADD;
            endcase
            clc         <= ir == 8'h18;
            sec         <= ir == 8'h38;
            cld         <= ir == 8'hD8;
            sed         <= ir == 8'hF8;
        end
    end

endmodule

`default_nettype wire

//--- cpu_pkg.sv
// Shared types of the 6502-style core
// Bus vectors, sequencer states, addressing classes, ALU codes and register indices
`default_nettype none

`include "cpu_settings.svh"

package cpu_pkg;

    typedef logic [`DATA_W-1:0] byte_t;   // One data byte
    typedef logic [`ADDR_W-1:0] addr_t;   // One bus address

    // Sequencer states
    typedef enum logic [2:0] {
        BOOT,       // First fetch after reset
        DECODE,     // Opcode on data_mux, operand fetch
        FETCH,      // Next opcode fetch, ALU busy
        REG,        // Register-only cycle
        ZP0,        // Zero-page read or store
        READ,       // RMW modify cycle
        WRITE       // RMW write-back
    } state_t;

    typedef enum logic [1:0] {
        IMPLIED,
        IMMEDIATE,
        ZERO_PAGE
    } addr_mode_t;

    // Bits 1:0 pick the logic function, bits 3:2 the adder B term
    typedef enum logic [3:0] {
        OR   = 4'b1100,
        AND  = 4'b1101,
        EOR  = 4'b1110,
        ADD  = 4'b0011,
        SUB  = 4'b0111,
        ROL  = 4'b1011,
        PASS = 4'b1111
    } alu_op_t;

    typedef enum logic [1:0] {
        A,
        X,
        Y
    } reg_sel_t;

endpackage

`default_nettype wire

//--- cpu_settings.svh
// Width and address constants for the 6502-style core
// Included by the package and the sequencer
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define DATA_W    8         // Data bus width
`define ADDR_W    16        // Address bus width
`define ZERO_PAGE 8'h00     // High address byte of zero page
`define RESET_PC  16'h0200  // First opcode fetch after reset

`endif
